/* dv/bf16Model.svh */
`ifndef BF16_MODEL_SVH
`define BF16_MODEL_SVH

// reference rules for the accumulator, worked on plain integers.
// these functions are included inside the testbench module and see the
// package types through its import.

// a product with bit 8 set is halved, so its leading one lands on the
// hidden-one position and the exponent grows by one.
function automatic bf16_t normProduct(input product_t prod);
    bf16_t word;
    word.sign     = prod.sign;
    word.exponent = prod.exponent + {7'd0, prod.mantissa[`PROD_MAN_W-1]};
    word.fraction = prod.mantissa[`PROD_MAN_W-1] ? prod.mantissa[7:1] : prod.mantissa[6:0];
    return word;
endfunction

// the BFLOAT16 sum of one input item.
function automatic bf16_t expectedSum(input accIn_t item);
    bf16_t bigOp;
    bf16_t smallOp;
    bf16_t res;
    int    gap;
    int    bigMan;
    int    smallMan;
    int    total;
    int    outExp;
    bigOp   = normProduct(item.product);
    smallOp = item.prevSum;
    res     = '0;
    // a zero running sum leaves the product as it is.
    if (smallOp == '0) begin
        return bigOp;
    end
    if (smallOp.exponent > bigOp.exponent) begin
        bigOp   = item.prevSum;
        smallOp = normProduct(item.product);
    end
    gap = int'(bigOp.exponent) - int'(smallOp.exponent);
    // beyond the alignment limit the smaller operand has no effect at all.
    if (gap > `MAX_ALIGN_SHIFT) begin
        return bigOp;
    end
    bigMan   = (1 << `BF16_FRAC_W) + int'(bigOp.fraction);
    smallMan = ((1 << `BF16_FRAC_W) + int'(smallOp.fraction)) >> gap;
    outExp   = int'(bigOp.exponent);
    res.sign = bigOp.sign;
    if (bigOp.sign == smallOp.sign) begin
        total = bigMan + smallMan;
        // a carry past the hidden one costs one place of precision.
        if (total >= (2 << `BF16_FRAC_W)) begin
            total  = total >> 1;
            outExp = outExp + 1;
        end
    end else begin
        // with equal exponents the larger mantissa decides the sign.
        if (smallMan > bigMan) begin
            res.sign = smallOp.sign;
        end
        total = (bigMan >= smallMan) ? bigMan - smallMan : smallMan - bigMan;
        if (total == 0) begin
            return '0;
        end
        while (total < (1 << `BF16_FRAC_W)) begin
            total  = total << 1;
            outExp = outExp - 1;
        end
    end
    res.exponent = 8'(outExp);
    res.fraction = 7'(total);
    return res;
endfunction

`endif

/* dv/tbPeAccumulator.sv */
`default_nettype none

`include "bf16_defines.svh"

module tbPeAccumulator import bf16Pkg::*; ();

    localparam int NumSteady = 200;
    localparam int NumRandom = 300;
    // the clear test adds two items that never leave the pipeline.
    localparam int WatchdogCycles = (NumSteady + NumRandom + 2) * 40 + 200;

    logic        clk = 1'b0;
    logic        rstN = 1'b0;
    logic        clr;
    logic        inValid;
    logic        inReady;
    accIn_t      inData;
    logic        outValid;
    logic        outReady;
    bf16_t       outData;
    logic [15:0] lfsrState = 16'd38;
    logic        steadyReady;
    logic        randomReady;
    bf16_t       expQ[$];
    bf16_t       head;
    logic        headValid = 1'b0;
    int          valueErrors = 0;
    int          protocolErrors = 0;

    `include "bf16Model.svh"

    peAccumulator DUT (.*);

    always #5 clk = ~clk;

    //--------------------------------------------------------------------------
    // stimulus
    //--------------------------------------------------------------------------

    // a galois LFSR that is stepped once for every bit handed out.
    function automatic int takeBits(input int count);
        int value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 16'hB400 : 16'h0000);
        end
        return value;
    endfunction

    // two LFSR bits steer each item toward one mode.
    // kind 0 zeroes the sum, kind 1 opens a wide gap, kind 2 and 3 keep the
    // gap near with equal or opposite signs.
    function automatic accIn_t makeItem();
        accIn_t item;
        bf16_t  normP;
        int     kind;
        int     sExp;
        item.product.sign     = 1'(takeBits(1));
        item.product.exponent = 8'(48 + takeBits(7) + takeBits(5));
        item.product.mantissa = 9'(takeBits(9));
        // a product of two normalized mantissas is never below one.
        if (item.product.mantissa[8:7] == 2'b00) begin
            item.product.mantissa[7] = 1'b1;
        end
        normP = normProduct(item.product);
        kind  = takeBits(2);
        sExp  = int'(normP.exponent);
        if (kind == 1) begin
            sExp = sExp + (takeBits(1) == 1 ? 8 + takeBits(5) : -8 - takeBits(5));
        end else begin
            sExp = sExp + takeBits(4) - 7;
        end
        item.prevSum.sign     = (kind == 3) ? ~normP.sign : normP.sign;
        item.prevSum.exponent = 8'(sExp);
        item.prevSum.fraction = 7'(takeBits(7));
        if (kind == 0) begin
            item.prevSum = '0;
        end else if (kind == 3 && takeBits(2) == 0) begin
            // the exact negative of the product cancels to zero.
            item.prevSum.exponent = normP.exponent;
            item.prevSum.fraction = normP.fraction;
        end
        return item;
    endfunction

    // inputs change one unit after the rising edge.
    task automatic stepCycle();
        @(posedge clk);
        #1;
        if (randomReady) begin
            outReady = (takeBits(2) != 0);
        end
    endtask

    // the item stays on the input until the DUT takes it.
    task automatic sendItem(input accIn_t item);
        logic taken;
        taken   = 1'b0;
        inData  = item;
        inValid = 1'b1;
        while (!taken) begin
            @(negedge clk);
            taken = inReady;
            stepCycle();
        end
        inValid = 1'b0;
    endtask

    task automatic drainOutput();
        while (expQ.size() != 0) begin
            stepCycle();
        end
    endtask

    task automatic flagMismatch(input string name, input bf16_t expected, input bf16_t actual);
        valueErrors++;
        $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic noteViolation(input string what);
        protocolErrors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    //--------------------------------------------------------------------------
    // scoreboard and checks
    //--------------------------------------------------------------------------

    // the head is refreshed on the falling edge ahead of the transfer that it
    // describes, and the queue then follows the transfers of that edge.
    always @(negedge clk) begin
        headValid = (expQ.size() != 0);
        if (headValid) begin
            head = expQ[0];
        end
        if (clr) begin
            expQ.delete();
        end else begin
            if (outValid && outReady && headValid) begin
                void'(expQ.pop_front());
            end
            if (inValid && inReady) begin
                expQ.push_back(expectedSum(inData));
            end
        end
    end

    idleAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !outValid && inReady)
        else noteViolation("stream not idle after reset");

    idleAfterClear: assert property (@(posedge clk) disable iff (!rstN)
        clr |=> !outValid && inReady)
        else noteViolation("output still valid after a clear");

    // every output transfer takes the oldest outstanding item.
    expectedOutput: assert property (@(posedge clk) disable iff (!rstN)
        outValid && outReady |-> headValid)
        else noteViolation("output transfer with no item outstanding");

    outputValue: assert property (@(posedge clk) disable iff (!rstN)
        outValid && outReady && headValid |-> outData == head)
        else flagMismatch("outData", head, $sampled(outData));

    stalledHold: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady && !clr |=> outValid && $stable(outData))
        else noteViolation("outData not held while the output was stalled");

    // with the output always ready the pipeline is exactly two stages deep.
    twoCycleLatency: assert property (@(posedge clk) disable iff (!rstN || clr)
        inValid && inReady && steadyReady |-> ##2 outValid)
        else noteViolation("accepted item not on the output two cycles later");

    //--------------------------------------------------------------------------
    // test sequence
    //--------------------------------------------------------------------------

    initial begin
        clr         = 1'b0;
        inValid     = 1'b0;
        inData      = '0;
        outReady    = 1'b1;
        steadyReady = 1'b0;
        randomReady = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;
        stepCycle();
        // back-to-back items with the output always ready.
        steadyReady = 1'b1;
        repeat (NumSteady) sendItem(makeItem());
        drainOutput();
        steadyReady = 1'b0;
        // random back-pressure from the output side.
        randomReady = 1'b1;
        repeat (NumRandom) sendItem(makeItem());
        randomReady = 1'b0;
        outReady    = 1'b1;
        drainOutput();
        // two items stall in the pipeline and a clear drops them.
        outReady = 1'b0;
        repeat (2) sendItem(makeItem());
        clr = 1'b1;
        stepCycle();
        clr      = 1'b0;
        outReady = 1'b1;
        repeat (4) stepCycle();
        $display("value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // ends a run that stops making progress.
    initial begin
        #(WatchdogCycles * 10);
        $display("timeout: the run did not finish within %0d cycles", WatchdogCycles);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/bf16Pkg.sv */
`default_nettype none

`include "bf16_defines.svh"

package bf16Pkg;

    //----------------------------------------------------------------------------
    // operand formats
    //----------------------------------------------------------------------------

    // a plain BFLOAT16 word, laid out exactly as it sits in memory.
    typedef struct packed {
        logic                    sign;
        logic [`BF16_EXP_W-1:0]  exponent;
        logic [`BF16_FRAC_W-1:0] fraction;
    } bf16_t;

    // the multiplier output before normalization.
    // mantissa bits 8 and 7 are the two integer bits of the product.
    typedef struct packed {
        logic                   sign;
        logic [`BF16_EXP_W-1:0] exponent;
        logic [`PROD_MAN_W-1:0] mantissa;
    } product_t;

    // one accumulator input item holds the new product and the running sum.
    typedef struct packed {
        product_t product;
        bf16_t    prevSum;
    } accIn_t;

    //----------------------------------------------------------------------------
    // internal pipeline formats
    //----------------------------------------------------------------------------

    // how the merge stage builds the result from the two paths.
    typedef enum logic [1:0] {
        passProduct   = 2'd0,
        passLarger    = 2'd1,
        addMagnitudes = 2'd2,
        subMagnitudes = 2'd3
    } accMode_t;

    // operands after ordering and alignment.
    // the big operand keeps its exponent, the small one only its shifted mantissa.
    typedef struct packed {
        accMode_t               mode;
        logic                   bigSign;
        logic [`BF16_EXP_W-1:0] bigExp;
        logic [`BF16_MAN_W-1:0] bigMan;
        logic [`BF16_MAN_W-1:0] smallMan;
    } alignedPair_t;

    // a renormalized magnitude from the add or the subtract path.
    typedef struct packed {
        logic [`BF16_EXP_W-1:0]  exponent;
        logic [`BF16_FRAC_W-1:0] fraction;
        logic                    zero;
    } pathResult_t;

endpackage

`default_nettype wire

/* rtl/bf16_defines.svh */
`ifndef BF16_DEFINES_SVH
`define BF16_DEFINES_SVH

//--------------------------------------------------------------------------
// BFLOAT16 field widths
//--------------------------------------------------------------------------

// the biased exponent field of a BFLOAT16 word.
`define BF16_EXP_W 8

// the stored fraction, without the hidden one.
`define BF16_FRAC_W 7

// the mantissa once the hidden one is put back in front of the fraction.
`define BF16_MAN_W 8

// the product from the multiplier carries two integer bits, so it is one
// bit wider than a normalized mantissa.
`define PROD_MAN_W 9

// exponent gaps up to this value are aligned and combined.
// a wider gap shifts every mantissa bit out, so the larger operand wins.
`define MAX_ALIGN_SHIFT 7

`endif

/* rtl/magnitudeAdd.sv */
`default_nettype none

`include "bf16_defines.svh"

module magnitudeAdd import bf16Pkg::*; (
    input  wire alignedPair_t pair,
    output pathResult_t       sum
);

    localparam int ExpW = `BF16_EXP_W;
    localparam int ManW = `BF16_MAN_W;
    localparam logic [ExpW-1:0] ExpOne = 1;

    // one extra bit catches the carry out of the mantissa add.
    logic [ManW:0] rawSum;

    assign rawSum = {1'b0, pair.bigMan} + {1'b0, pair.smallMan};

    always_comb begin
        // two normalized mantissas can at most double, so one shift is enough.
        if (rawSum[ManW]) begin
            sum.exponent = pair.bigExp + ExpOne;
            sum.fraction = rawSum[ManW-1:1];
        end else begin
            sum.exponent = pair.bigExp;
            sum.fraction = rawSum[`BF16_FRAC_W-1:0];
        end
        // the big mantissa has its hidden one, so a sum is never zero.
        sum.zero = 1'b0;
    end

endmodule

`default_nettype wire

/* rtl/magnitudeSub.sv */
`default_nettype none

`include "bf16_defines.svh"

module magnitudeSub import bf16Pkg::*; (
    input  wire alignedPair_t pair,
    output pathResult_t       difference
);

    localparam int ExpW   = `BF16_EXP_W;
    localparam int ManW   = `BF16_MAN_W;
    localparam int ShiftW = $clog2(ManW);

    // the top bit is the borrow, kept only so it can be checked.
    logic [ManW:0]     rawDiff;
    logic [ShiftW-1:0] leadShift;
    logic [ManW-1:0]   normDiff;

    assign rawDiff = {1'b0, pair.bigMan} - {1'b0, pair.smallMan};

    //--------------------------------------------------------------------------
    // leading-one search
    //--------------------------------------------------------------------------

    // scanning upward lets the highest set bit win.
    // the shift is how far that bit sits below the hidden-one position.
    always_comb begin
        leadShift = '0;
        for (int i = 0; i < ManW; i++) begin
            if (rawDiff[i]) begin
                leadShift = ShiftW'(ManW - 1 - i);
            end
        end
    end

    assign normDiff = rawDiff[ManW-1:0] << leadShift;

    always_comb begin
        difference.exponent = pair.bigExp - {{(ExpW - ShiftW){1'b0}}, leadShift};
        difference.fraction = normDiff[`BF16_FRAC_W-1:0];
        // exact cancellation has no leading one at all.
        difference.zero     = (rawDiff[ManW-1:0] == '0);
    end

    // the alignment stage orders the operands, so a borrow never occurs.
    always_comb begin
        if (pair.mode == subMagnitudes) begin
            assert (!rawDiff[ManW]);
        end
    end

endmodule

`default_nettype wire

/* rtl/operandAlign.sv */
`default_nettype none

`include "bf16_defines.svh"

module operandAlign import bf16Pkg::*; (
    input  wire accIn_t       operands,
    output alignedPair_t      aligned
);

    localparam int ExpW = `BF16_EXP_W;
    localparam int ManW = `BF16_MAN_W;
    localparam logic [ExpW-1:0] MaxShift = `MAX_ALIGN_SHIFT;
    localparam logic [ExpW-1:0] ExpOne = 1;

    logic [ManW-1:0] prodMan;
    logic [ExpW-1:0] prodExp;
    logic [ManW-1:0] accMan;
    logic            sumZero;
    logic            productBig;
    logic            bigSign;
    logic [ExpW-1:0] bigExp;
    logic [ManW-1:0] bigMan;
    logic [ExpW-1:0] smallExp;
    logic [ManW-1:0] smallRaw;
    logic [ExpW-1:0] expGap;
    accMode_t        mode;

    //--------------------------------------------------------------------------
    // product normalization
    //--------------------------------------------------------------------------

    // a set bit 8 means the product reached two or more, so one place of
    // mantissa moves into the exponent.
    always_comb begin
        if (operands.product.mantissa[`PROD_MAN_W-1]) begin
            prodMan = operands.product.mantissa[`PROD_MAN_W-1:1];
            prodExp = operands.product.exponent + ExpOne;
        end else begin
            prodMan = operands.product.mantissa[ManW-1:0];
            prodExp = operands.product.exponent;
        end
    end

    // the running sum is stored normalized, so only the hidden one is missing.
    assign accMan  = {1'b1, operands.prevSum.fraction};
    assign sumZero = (operands.prevSum == '0);

    // comparing exponent and mantissa as one number orders by magnitude.
    // an all-zero running sum always loses, so the product passes through.
    assign productBig = sumZero || ({prodExp, prodMan} >= {operands.prevSum.exponent, accMan});

    //--------------------------------------------------------------------------
    // operand ordering and alignment
    //--------------------------------------------------------------------------

    always_comb begin
        if (productBig) begin
            bigSign  = operands.product.sign;
            bigExp   = prodExp;
            bigMan   = prodMan;
            smallExp = operands.prevSum.exponent;
            smallRaw = accMan;
        end else begin
            bigSign  = operands.prevSum.sign;
            bigExp   = operands.prevSum.exponent;
            bigMan   = accMan;
            smallExp = prodExp;
            smallRaw = prodMan;
        end
    end

    // ordering makes the gap non-negative.
    assign expGap = bigExp - smallExp;

    always_comb begin
        if (sumZero) begin
            mode = passProduct;
        end else if (expGap > MaxShift) begin
            mode = passLarger;
        end else if (operands.product.sign == operands.prevSum.sign) begin
            mode = addMagnitudes;
        end else begin
            mode = subMagnitudes;
        end
    end

    always_comb begin
        aligned.mode    = mode;
        aligned.bigSign = bigSign;
        aligned.bigExp  = bigExp;
        aligned.bigMan  = bigMan;
        // nothing of the small operand survives a pass-through.
        if (sumZero || expGap > MaxShift) begin
            aligned.smallMan = '0;
        end else begin
            aligned.smallMan = smallRaw >> expGap;
        end
    end

    // the subtract path relies on the ordering to never go negative.
    always_comb begin
        if (aligned.mode == addMagnitudes || aligned.mode == subMagnitudes) begin
            assert (aligned.bigMan >= aligned.smallMan);
        end
    end

endmodule

`default_nettype wire

/* rtl/peAccumulator.sv */
`default_nettype none

`include "bf16_defines.svh"

module peAccumulator import bf16Pkg::*; (
    input  wire logic   clk,
    input  wire logic   rstN,
    input  wire logic   clr,
    input  wire logic   inValid,
    output logic        inReady,
    input  wire accIn_t inData,
    output logic        outValid,
    input  wire logic   outReady,
    output bf16_t       outData
);

    alignedPair_t alignIn;
    alignedPair_t alignOut;
    logic         alignValid;
    logic         alignReady;
    pathResult_t  sumPath;
    pathResult_t  diffPath;
    bf16_t        mergedResult;

    //--------------------------------------------------------------------------
    // stage one normalizes, orders and aligns the operands
    //--------------------------------------------------------------------------

    operandAlign uOperandAlign (
        .operands (inData),
        .aligned  (alignIn)
    );

    stageReg #(
        .payload_t (alignedPair_t)
    ) alignStage (
        .clk       (clk),
        .rstN      (rstN),
        .clr       (clr),
        .upValid   (inValid),
        .upReady   (inReady),
        .upData    (alignIn),
        .downValid (alignValid),
        .downReady (alignReady),
        .downData  (alignOut)
    );

    //--------------------------------------------------------------------------
    // stage two runs both magnitude paths and then the merge
    //--------------------------------------------------------------------------

    magnitudeAdd uMagnitudeAdd (
        .pair (alignOut),
        .sum  (sumPath)
    );

    magnitudeSub uMagnitudeSub (
        .pair       (alignOut),
        .difference (diffPath)
    );

    resultMerge uResultMerge (
        .pair       (alignOut),
        .sum        (sumPath),
        .difference (diffPath),
        .result     (mergedResult)
    );

    stageReg #(
        .payload_t (bf16_t)
    ) outStage (
        .clk       (clk),
        .rstN      (rstN),
        .clr       (clr),
        .upValid   (alignValid),
        .upReady   (alignReady),
        .upData    (mergedResult),
        .downValid (outValid),
        .downReady (outReady),
        .downData  (outData)
    );

endmodule

`default_nettype wire

/* rtl/resultMerge.sv */
`default_nettype none

`include "bf16_defines.svh"

module resultMerge import bf16Pkg::*; (
    input  wire alignedPair_t pair,
    input  wire pathResult_t  sum,
    input  wire pathResult_t  difference,
    output bf16_t             result
);

    //--------------------------------------------------------------------------
    // result selection
    //--------------------------------------------------------------------------

    // both paths run on every item.
    // the mode picks the one that applies.
    always_comb begin
        result = '0;
        case (pair.mode)
            passProduct, passLarger: begin
                // the big operand is already normalized, so only the hidden
                // one is dropped.
                result.sign     = pair.bigSign;
                result.exponent = pair.bigExp;
                result.fraction = pair.bigMan[`BF16_FRAC_W-1:0];
            end
            addMagnitudes: begin
                result.sign     = pair.bigSign;
                result.exponent = sum.exponent;
                result.fraction = sum.fraction;
            end
            subMagnitudes: begin
                // the larger aligned magnitude decides the sign.
                // exact cancellation gives a positive zero word.
                if (difference.zero) begin
                    result = '0;
                end else begin
                    result.sign     = pair.bigSign;
                    result.exponent = difference.exponent;
                    result.fraction = difference.fraction;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* rtl/stageReg.sv */
`default_nettype none

`include "bf16_defines.svh"

module stageReg import bf16Pkg::*; #(
    parameter type payload_t = bf16_t
) (
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire logic     clr,
    input  wire logic     upValid,
    output logic          upReady,
    input  wire payload_t upData,
    output logic          downValid,
    input  wire logic     downReady,
    output payload_t      downData
);

    logic     full;
    payload_t dataQ;

    // the slot can take a new item when it is empty or when the held item
    // leaves on the same edge.
    // nothing is taken while a clear is flushing the pipeline.
    assign upReady   = !clr && (!full || downReady);
    assign downValid = full;
    assign downData  = dataQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            full <= 1'b0;
        end else if (clr) begin
            full <= 1'b0;
        end else if (upReady) begin
            full <= upValid;
        end
    end

    always_ff @(posedge clk) begin
        if (upValid && upReady) begin
            dataQ <= upData;
        end
    end

    // a stalled item stays put until the downstream side takes it.
    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        downValid && !downReady && !clr |=> downValid && $stable(downData));

    // a clear empties the stage by the next cycle.
    emptyAfterClear: assert property (@(posedge clk) disable iff (!rstN)
        clr |=> !downValid);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tbPeAccumulator -o simPe
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simPe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All checks passed" sim.log; then
    exit 0
fi
exit 1

/* verilog.f */
+incdir+rtl
+incdir+dv
rtl/bf16Pkg.sv
rtl/operandAlign.sv
rtl/stageReg.sv
rtl/magnitudeAdd.sv
rtl/magnitudeSub.sv
rtl/resultMerge.sv
rtl/peAccumulator.sv
dv/tbPeAccumulator.sv
